/* common/bus_pkg.sv */
/*
 * Bus package
 * Widths, data types and response codes of the single-master
 * request bus. The response codes follow the AXI encoding.
 */

package bus_pkg;

  // --------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Byte address and data word
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // One enable bit per data byte
  typedef logic [DataWidth/8-1:0] be_t;

  // --------------------------------------------------------------------
  // Response codes
  // --------------------------------------------------------------------
  // Same values as the AXI RRESP/BRESP field, EXOKAY is never returned
  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10,
    RespDecErr = 2'b11
  } resp_e;

endpackage

/* common/soc_map_pkg.sv */
/*
 * SoC map package
 * Address windows of the boot ROM, GPIO and DRAM targets, the target
 * select enum, memory sizes and the debug request hold-off time.
 */

package soc_map_pkg;

  // --------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------
  localparam bus_pkg::addr_t RomBase    = 32'h0001_0000;
  localparam bus_pkg::addr_t RomLength  = 32'h0001_0000;
  localparam bus_pkg::addr_t GpioBase   = 32'h4000_0000;
  localparam bus_pkg::addr_t GpioLength = 32'h0000_1000;
  localparam bus_pkg::addr_t DramBase   = 32'h8000_0000;
  localparam bus_pkg::addr_t DramLength = 32'h4000_0000;

  // Decoded target, TgtNone for any miss
  typedef enum logic [1:0] {
    TgtRom,
    TgtDram,
    TgtGpio,
    TgtNone
  } target_e;

  // Memory sizes in words
  localparam int unsigned RomWords  = 8;
  localparam int unsigned DramWords = 256;

  typedef logic [2:0] rom_idx_t;
  typedef logic [7:0] dram_idx_t;
  // Wide enough for either index
  typedef logic [7:0] offset_t;

  // Boot window before debug requests reach the core
  localparam int unsigned DebugDelayCycles = 500;

endpackage

/* common/bus_stage_if.sv */
/*
 * Decode to access stage bus
 * Carries one registered, already decoded request from the
 * address decode stage to the memory access stage.
 */

`timescale 1ns/10ps

interface bus_stage_if;

  logic                 valid;
  logic                 we;
  soc_map_pkg::target_e target;
  soc_map_pkg::offset_t offset;
  bus_pkg::data_t       wdata;
  bus_pkg::be_t         be;

  // Decode stage owns every field
  modport decode (
    output valid, we, target, offset, wdata, be
  );

  modport access (
    input  valid, we, target, offset, wdata, be
  );

endinterface

/* memory/boot_rom.sv */
/*
 * Boot ROM
 * Eight-word combinational table. The boot code loads the DRAM base
 * into t0 and jumps there, the remaining words are no-ops.
 */

`timescale 1ns/10ps

module boot_rom (
  input  soc_map_pkg::rom_idx_t addr_i,
  output bus_pkg::data_t        rdata_o
);

  // --------------------------------------------------------------------
  // Instruction table
  // --------------------------------------------------------------------
  always_comb begin : p_table
    case (addr_i)
      // lui t0, 0x80000
      3'd0:    rdata_o = 32'h8000_02B7;
      // jalr x0, 0(t0)
      3'd1:    rdata_o = 32'h0002_8067;
      // Padding, addi x0, x0, 0
      3'd2:    rdata_o = 32'h0000_0013;
      3'd3:    rdata_o = 32'h0000_0013;
      3'd4:    rdata_o = 32'h0000_0013;
      3'd5:    rdata_o = 32'h0000_0013;
      3'd6:    rdata_o = 32'h0000_0013;
      3'd7:    rdata_o = 32'h0000_0013;
      default: rdata_o = 32'h0000_0013;
    endcase
  end

endmodule

/* memory/mem_access_stage.sv */
/*
 * Memory access stage
 * Second pipeline stage. Writes the DRAM under byte enables, reads
 * the DRAM or the boot ROM, answers GPIO and unmapped requests as an
 * error target and registers the response pulse, data and code.
 */

`timescale 1ns/10ps

module mem_access_stage (
  input  logic            clk_i,
  input  logic            rst_ni,
  bus_stage_if.access     stage_i,
  output logic            rvalid_o,
  output bus_pkg::data_t  rdata_o,
  output bus_pkg::resp_e  resp_o
);

  bus_pkg::data_t         mem_q [soc_map_pkg::DramWords];
  soc_map_pkg::dram_idx_t dram_idx;
  logic                   dram_we;
  bus_pkg::data_t         dram_rdata;
  bus_pkg::data_t         rom_rdata;
  bus_pkg::data_t         rdata_d;
  bus_pkg::resp_e         resp_d;

  boot_rom i_boot_rom (
    .addr_i  ( soc_map_pkg::rom_idx_t'(stage_i.offset) ),
    .rdata_o ( rom_rdata                               )
  );

  // --------------------------------------------------------------------
  // DRAM
  // --------------------------------------------------------------------
  assign dram_idx   = soc_map_pkg::dram_idx_t'(stage_i.offset);
  assign dram_we    = stage_i.valid && stage_i.we && (stage_i.target == soc_map_pkg::TgtDram);
  assign dram_rdata = mem_q[dram_idx];

  always_ff @(posedge clk_i) begin : p_dram_write
    if (dram_we) begin
      for (int b = 0; b < bus_pkg::DataWidth/8; b++) begin
        if (stage_i.be[b]) begin
          mem_q[dram_idx][8*b +: 8] <= stage_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // Response select
  // --------------------------------------------------------------------
  always_comb begin : p_resp
    rdata_d = '0;
    resp_d  = bus_pkg::RespOkay;
    case (stage_i.target)
      soc_map_pkg::TgtRom: begin
        if (stage_i.we) begin
          resp_d = bus_pkg::RespSlvErr;
        end else if (stage_i.offset < soc_map_pkg::RomWords) begin
          rdata_d = rom_rdata;
        end
      end
      soc_map_pkg::TgtDram: begin
        // Writes answer with zero data
        if (!stage_i.we) begin
          rdata_d = dram_rdata;
        end
      end
      // GPIO is not implemented
      soc_map_pkg::TgtGpio: resp_d = bus_pkg::RespSlvErr;
      default:              resp_d = bus_pkg::RespDecErr;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rvalid
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= stage_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin : p_rdata
    if (stage_i.valid) begin
      rdata_o <= rdata_d;
      resp_o  <= resp_d;
    end
  end

  a_rvalid_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(rvalid_o));

endmodule

/* rtl/addr_decode_stage.sv */
/*
 * Address decode stage
 * First pipeline stage. Matches the request address against the
 * ROM, GPIO and DRAM windows, computes the word offset inside the
 * selected window and registers the request for the access stage.
 */

`timescale 1ns/10ps

module addr_decode_stage (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  logic            we_i,
  input  bus_pkg::addr_t  addr_i,
  input  bus_pkg::data_t  wdata_i,
  input  bus_pkg::be_t    be_i,
  bus_stage_if.decode     stage_o
);

  soc_map_pkg::target_e             target_d;
  soc_map_pkg::offset_t             offset_d;
  bus_pkg::addr_t                   rel_addr;
  logic [bus_pkg::AddrWidth-3:0]    word_idx;

  // --------------------------------------------------------------------
  // Window match
  // --------------------------------------------------------------------
  always_comb begin : p_decode
    target_d = soc_map_pkg::TgtNone;
    rel_addr = '0;
    if (addr_i >= soc_map_pkg::RomBase &&
        addr_i <  soc_map_pkg::RomBase + soc_map_pkg::RomLength) begin
      target_d = soc_map_pkg::TgtRom;
      rel_addr = addr_i - soc_map_pkg::RomBase;
    end else if (addr_i >= soc_map_pkg::GpioBase &&
                 addr_i <  soc_map_pkg::GpioBase + soc_map_pkg::GpioLength) begin
      target_d = soc_map_pkg::TgtGpio;
      rel_addr = addr_i - soc_map_pkg::GpioBase;
    end else if (addr_i >= soc_map_pkg::DramBase &&
                 addr_i <  soc_map_pkg::DramBase + soc_map_pkg::DramLength) begin
      target_d = soc_map_pkg::TgtDram;
      rel_addr = addr_i - soc_map_pkg::DramBase;
    end
  end

  assign word_idx = rel_addr[bus_pkg::AddrWidth-1:2];

  // Word offset, DRAM wraps and ROM words past the table map to RomWords
  always_comb begin : p_offset
    case (target_d)
      soc_map_pkg::TgtRom: begin
        offset_d = (word_idx < soc_map_pkg::RomWords) ?
                   soc_map_pkg::offset_t'(word_idx) :
                   soc_map_pkg::offset_t'(soc_map_pkg::RomWords);
      end
      soc_map_pkg::TgtDram: begin
        offset_d = soc_map_pkg::offset_t'(soc_map_pkg::dram_idx_t'(word_idx));
      end
      default: offset_d = '0;
    endcase
  end

  // --------------------------------------------------------------------
  // Stage registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      stage_o.valid <= 1'b0;
    end else begin
      stage_o.valid <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (req_i) begin
      stage_o.we     <= we_i;
      stage_o.target <= target_d;
      stage_o.offset <= offset_d;
      stage_o.wdata  <= wdata_i;
      stage_o.be     <= be_i;
    end
  end

  // A request seen by the access stage always carries a resolved target
  a_target_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    stage_o.valid |-> !$isunknown(stage_o.target));

endmodule

/* rtl/debug_req_gate.sv */
/*
 * Debug request gate
 * Holds the external debug request off for a fixed boot window after
 * reset, and at any time while debugging is disabled.
 */

`timescale 1ns/10ps

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic dbg_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  typedef logic [$clog2(soc_map_pkg::DebugDelayCycles+1)-1:0] cnt_t;

  cnt_t cnt_q;

  // Countdown that stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_delay_cnt
    if (!rst_ni) begin
      cnt_q <= cnt_t'(soc_map_pkg::DebugDelayCycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - cnt_t'(1);
    end
  end

  // Pass the request only after the boot window
  assign debug_req_o = (cnt_q == '0) && debug_enable_i && dbg_req_i;

  a_held_off : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q != '0) |-> !debug_req_o);

endmodule

/* rtl/soc_harness_top.sv */
/*
 * SoC harness top
 * Two-stage memory pipeline behind a single request port, serving
 * the boot ROM, DRAM and error targets, plus the debug request gate.
 */

`timescale 1ns/10ps

module soc_harness_top (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  logic            we_i,
  input  bus_pkg::addr_t  addr_i,
  input  bus_pkg::data_t  wdata_i,
  input  bus_pkg::be_t    be_i,
  output logic            rvalid_o,
  output bus_pkg::data_t  rdata_o,
  output bus_pkg::resp_e  resp_o,
  input  logic            dbg_req_i,
  input  logic            debug_enable_i,
  output logic            debug_req_o
);

  bus_stage_if stage_bus ();

  // --------------------------------------------------------------------
  // Memory pipeline
  // --------------------------------------------------------------------
  addr_decode_stage i_addr_decode_stage (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .req_i   ( req_i     ),
    .we_i    ( we_i      ),
    .addr_i  ( addr_i    ),
    .wdata_i ( wdata_i   ),
    .be_i    ( be_i      ),
    .stage_o ( stage_bus )
  );

  mem_access_stage i_mem_access_stage (
    .clk_i    ( clk_i     ),
    .rst_ni   ( rst_ni    ),
    .stage_i  ( stage_bus ),
    .rvalid_o ( rvalid_o  ),
    .rdata_o  ( rdata_o   ),
    .resp_o   ( resp_o    )
  );

  // --------------------------------------------------------------------
  // Debug
  // --------------------------------------------------------------------
  debug_req_gate i_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .dbg_req_i      ( dbg_req_i      ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

/* tb/tb_soc_harness.sv */
/*
 * SoC harness testbench
 * Directed tests of the boot ROM, DRAM and error targets through the
 * two-stage request pipeline, and of the debug request hold-off.
 */

`timescale 1ns/10ps

module tb_soc_harness;

  // Debug delay plus the bus tests, with margin
  localparam int unsigned TimeoutCycles = 2000;

  logic           clk_i;
  logic           rst_ni;
  logic           req_i;
  logic           we_i;
  bus_pkg::addr_t addr_i;
  bus_pkg::data_t wdata_i;
  bus_pkg::be_t   be_i;
  logic           rvalid_o;
  bus_pkg::data_t rdata_o;
  bus_pkg::resp_e resp_o;
  logic           dbg_req_i;
  logic           debug_enable_i;
  logic           debug_req_o;

  bus_pkg::data_t rom_ref [soc_map_pkg::RomWords];
  bus_pkg::data_t dram_ref [soc_map_pkg::DramWords];
  // Expected responses, oldest first, one entry per bus cycle
  logic           exp_v_q [$];
  bus_pkg::data_t exp_d_q [$];
  bus_pkg::resp_e exp_r_q [$];
  string          cur_test;
  int unsigned    error_cnt;
  int unsigned    tests_run;
  int unsigned    tests_failed;
  int unsigned    cycle_cnt;

  soc_harness_top i_soc_harness_top (.*);

  initial begin : p_clock
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin : p_timeout
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, test %s did not finish", cycle_cnt, cur_test);
    $display("RESULT: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------
  task automatic check_data(string what, bus_pkg::data_t exp, bus_pkg::data_t act);
    if (act !== exp) begin
      error_cnt++;
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_resp(string what, bus_pkg::resp_e exp, bus_pkg::resp_e act);
    if (act !== exp) begin
      error_cnt++;
      $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    if (act !== exp) begin
      error_cnt++;
      $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // --------------------------------------------------------------------
  // Bus driving
  // --------------------------------------------------------------------
  // One bus cycle, the response is due two edges after its request
  task automatic advance(logic v, bus_pkg::data_t d, bus_pkg::resp_e r);
    logic v_old;
    exp_v_q.push_back(v);
    exp_d_q.push_back(d);
    exp_r_q.push_back(r);
    @(posedge clk_i);
    #2;
    if (exp_v_q.size() >= 2) begin
      v_old = exp_v_q.pop_front();
      check_bit("rvalid_o", v_old, rvalid_o);
      if (v_old) begin
        check_data("rdata_o", exp_d_q.pop_front(), rdata_o);
        check_resp("resp_o", exp_r_q.pop_front(), resp_o);
      end else begin
        void'(exp_d_q.pop_front());
        void'(exp_r_q.pop_front());
      end
    end
  endtask

  task automatic idle();
    req_i = 1'b0;
    advance(1'b0, '0, bus_pkg::RespOkay);
  endtask

  // Drives one request and works out its response from the address map
  task automatic issue(logic we, bus_pkg::addr_t addr, bus_pkg::data_t wdata,
                       bus_pkg::be_t be);
    bus_pkg::data_t exp_d;
    bus_pkg::resp_e exp_r;
    int unsigned    idx;
    exp_d = '0;
    exp_r = bus_pkg::RespOkay;
    if (addr >= soc_map_pkg::RomBase &&
        addr <  soc_map_pkg::RomBase + soc_map_pkg::RomLength) begin
      idx = (addr - soc_map_pkg::RomBase) >> 2;
      if (we) exp_r = bus_pkg::RespSlvErr;
      else if (idx < soc_map_pkg::RomWords) exp_d = rom_ref[idx];
    end else if (addr >= soc_map_pkg::GpioBase &&
                 addr <  soc_map_pkg::GpioBase + soc_map_pkg::GpioLength) begin
      exp_r = bus_pkg::RespSlvErr;
    end else if (addr >= soc_map_pkg::DramBase &&
                 addr <  soc_map_pkg::DramBase + soc_map_pkg::DramLength) begin
      // DRAM words repeat every 1 KiB
      idx = ((addr - soc_map_pkg::DramBase) >> 2) % soc_map_pkg::DramWords;
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) dram_ref[idx][8*b +: 8] = wdata[8*b +: 8];
        end
      end else begin
        exp_d = dram_ref[idx];
      end
    end else begin
      exp_r = bus_pkg::RespDecErr;
    end
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
    advance(1'b1, exp_d, exp_r);
  endtask

  task automatic end_test(int unsigned err0);
    tests_run++;
    if (error_cnt == err0) begin
      $display("Test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s: %0d checks failed", cur_test, error_cnt - err0);
    end
  endtask

  // --------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------
  task automatic test_reset_state();
    int unsigned err0;
    err0 = error_cnt;
    cur_test = "reset_state";
    for (int c = 0; c < 3; c++) begin
      @(posedge clk_i);
      #2;
      check_bit("rvalid_o", 1'b0, rvalid_o);
      check_bit("debug_req_o", 1'b0, debug_req_o);
      // Release after two cycles, the third sample is the first one after
      if (c == 1) begin
        rst_ni = 1'b1;
      end
    end
    end_test(err0);
  endtask

  task automatic test_rom();
    int unsigned err0;
    err0 = error_cnt;
    cur_test = "rom_access";
    for (int k = 0; k < soc_map_pkg::RomWords; k++) begin
      issue(1'b0, soc_map_pkg::RomBase + 4 * k, '0, 4'hF);
    end
    issue(1'b1, soc_map_pkg::RomBase + 32'h8, 32'hDEAD_BEEF, 4'hF);
    issue(1'b0, soc_map_pkg::RomBase + 32'h8, '0, 4'hF);
    repeat (2) idle();
    end_test(err0);
  endtask

  task automatic test_dram();
    bus_pkg::addr_t addrs [32];
    int unsigned    err0;
    err0 = error_cnt;
    cur_test = "dram_write_pipeline";
    issue(1'b1, soc_map_pkg::DramBase + 32'h10, 32'h1122_3344, 4'hF);
    issue(1'b1, soc_map_pkg::DramBase + 32'h10, 32'hAABB_CCDD, 4'b0101);
    issue(1'b0, soc_map_pkg::DramBase + 32'h10, '0, 4'hF);
    for (int i = 0; i < 32; i++) begin
      addrs[i] = soc_map_pkg::DramBase + ($urandom() & 32'h3FFF_FFFC);
      issue(1'b1, addrs[i], $urandom(), 4'hF);
    end
    for (int i = 0; i < 32; i++) begin
      issue(1'b0, addrs[i], '0, 4'hF);
    end
    // Aliases 1 KiB apart
    issue(1'b1, soc_map_pkg::DramBase + 32'h40, 32'hCAFE_0001, 4'hF);
    issue(1'b0, soc_map_pkg::DramBase + 32'h440, '0, 4'hF);
    issue(1'b1, soc_map_pkg::DramBase + 32'h840, 32'hCAFE_0002, 4'hF);
    issue(1'b0, soc_map_pkg::DramBase + 32'h40, '0, 4'hF);
    repeat (2) idle();
    end_test(err0);
  endtask

  task automatic test_error_targets();
    int unsigned err0;
    err0 = error_cnt;
    cur_test = "error_targets";
    issue(1'b0, soc_map_pkg::GpioBase + 32'h10, '0, 4'hF);
    issue(1'b1, soc_map_pkg::GpioBase + 32'h20, 32'h0000_00FF, 4'hF);
    issue(1'b0, 32'h2000_0000, '0, 4'hF);
    issue(1'b0, 32'hC000_0000, '0, 4'hF);
    repeat (2) idle();
    end_test(err0);
  endtask

  task automatic test_debug_gate();
    int unsigned err0;
    err0 = error_cnt;
    cur_test = "debug_gate";
    rst_ni         = 1'b0;
    dbg_req_i      = 1'b1;
    debug_enable_i = 1'b1;
    exp_v_q.delete();
    exp_d_q.delete();
    exp_r_q.delete();
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int k = 1; k <= soc_map_pkg::DebugDelayCycles; k++) begin
      @(posedge clk_i);
      #2;
      check_bit("debug_req_o", k == soc_map_pkg::DebugDelayCycles, debug_req_o);
    end
    // Output follows the request once the window has passed
    dbg_req_i = 1'b0;
    #1;
    check_bit("debug_req_o request low", 1'b0, debug_req_o);
    dbg_req_i      = 1'b1;
    debug_enable_i = 1'b0;
    #1;
    check_bit("debug_req_o disabled", 1'b0, debug_req_o);
    end_test(err0);
  endtask

  initial begin : p_main
    void'($urandom(16));
    error_cnt      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    cur_test       = "init";
    rst_ni         = 1'b0;
    req_i          = 1'b0;
    we_i           = 1'b0;
    addr_i         = '0;
    wdata_i        = '0;
    be_i           = '0;
    dbg_req_i      = 1'b1;
    debug_enable_i = 1'b1;
    // lui t0, 0x80000 then jalr x0, 0(t0), the rest addi x0, x0, 0
    rom_ref[0] = 32'h8000_02B7;
    rom_ref[1] = 32'h0002_8067;
    for (int k = 2; k < soc_map_pkg::RomWords; k++) rom_ref[k] = 32'h0000_0013;

    test_reset_state();
    test_rom();
    test_dram();
    test_error_targets();
    test_debug_gate();

    $display("Tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, error_cnt);
    if (error_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
common/bus_pkg.sv
common/soc_map_pkg.sv
common/bus_stage_if.sv
memory/boot_rom.sv
memory/mem_access_stage.sv
rtl/addr_decode_stage.sv
rtl/debug_req_gate.sv
rtl/soc_harness_top.sv
tb/tb_soc_harness.sv
